/* Makefile */
# rename unit simulation with Verilator

VERILATOR = verilator
FLAGS     = --binary --timing --assert
TOP       = rename_unit_tb
FILELIST  = sim.f
BUILD     = obj_dir

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench and run it, fails unless it passes"
	@echo "  clean  remove the build directory"

test:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	@out="$$(./$(BUILD)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -F -q '>>> PASS'

clean:
	rm -rf $(BUILD)

/* dv/rename_testdata.hex */
// test | decode: valid op src1 src2 dest | retire: valid tag
// expected: dispatch valid op psrc1 psrc2 new old alloc | ready | free_count, all hex
// ready is for this line's inputs, dispatch and free_count follow its rising edge
// ff in the test column ends the vectors
1 0 0 00 00 00 0 00  0 0 00 00 00 00 0 1 10
1 1 0 03 00 05 0 00  1 0 03 00 20 05 1 1 0f
1 1 0 07 09 06 0 00  1 0 07 09 21 06 1 1 0e
1 1 1 01 02 08 0 00  1 1 01 02 22 08 1 1 0d
2 1 0 05 06 0a 0 00  1 0 20 21 23 0a 1 1 0c
2 1 0 0a 08 0a 0 00  1 0 23 22 24 23 1 1 0b
2 1 0 0a 05 0b 0 00  1 0 24 20 25 0b 1 1 0a
2 1 0 05 00 05 0 00  1 0 20 00 26 20 1 1 09
3 1 2 0b 0a 0c 0 00  1 2 25 24 00 00 0 1 09
3 1 3 05 06 00 0 00  1 3 26 21 00 00 0 1 09
3 1 0 08 0b 00 0 00  1 0 22 25 00 00 0 1 09
3 1 1 00 00 00 0 00  1 1 00 00 00 00 0 1 09
3 0 0 01 02 03 0 00  0 0 00 00 00 00 0 1 09
4 1 0 01 02 0c 0 00  1 0 01 02 27 0c 1 1 08
4 1 0 01 02 0d 0 00  1 0 01 02 28 0d 1 1 07
4 1 0 01 02 0e 0 00  1 0 01 02 29 0e 1 1 06
4 1 0 01 02 0f 0 00  1 0 01 02 2a 0f 1 1 05
4 1 0 01 02 10 0 00  1 0 01 02 2b 10 1 1 04
4 1 0 01 02 11 0 00  1 0 01 02 2c 11 1 1 03
4 1 0 01 02 12 0 00  1 0 01 02 2d 12 1 1 02
4 1 0 01 02 13 0 00  1 0 01 02 2e 13 1 1 01
4 1 0 01 02 14 0 00  1 0 01 02 2f 14 1 1 00
4 1 0 0c 00 15 0 00  0 0 00 00 00 00 0 0 00
4 1 2 0c 14 00 0 00  1 2 27 2f 00 00 0 1 00
4 1 0 0c 00 15 1 05  0 0 00 00 00 00 0 0 01
4 1 0 0c 00 15 0 00  1 0 27 00 05 15 1 1 00
5 0 0 00 00 00 1 06  0 0 00 00 00 00 0 1 01
5 0 0 00 00 00 1 08  0 0 00 00 00 00 0 1 02
5 0 0 00 00 00 1 0a  0 0 00 00 00 00 0 1 03
5 1 0 15 00 16 0 00  1 0 05 00 06 16 1 1 02
5 1 0 16 15 17 1 0b  1 0 06 05 08 17 1 1 02
5 1 0 00 00 18 1 0c  1 0 00 00 0a 18 1 1 02
5 1 0 00 00 19 0 00  1 0 00 00 0b 19 1 1 01
5 1 0 00 00 1a 0 00  1 0 00 00 0c 1a 1 1 00
5 1 0 00 00 1b 0 00  0 0 00 00 00 00 0 0 00
5 0 0 00 00 00 0 00  0 0 00 00 00 00 0 1 00
5 0 0 00 00 00 1 0d  0 0 00 00 00 00 0 1 01
5 1 0 17 18 1b 1 0e  1 0 08 0a 0d 1b 1 1 01
5 1 0 1b 1b 1b 0 00  1 0 0d 0d 0e 0d 1 1 00
5 0 0 00 00 00 0 00  0 0 00 00 00 00 0 1 00
ff 0 0 00 00 00 0 00  0 0 00 00 00 00 0 0 00

/* dv/rename_unit_tb.sv */
//////////////////////////////////////////////////
// rename unit testbench
// drives decode and retire from a vector file and
// checks dispatch, ready and free count
//////////////////////////////////////////////////

`timescale 1ns/100ps

module rename_unit_tb;
    import rename_pkg::*;

    localparam int         clk_period  = 8;
    localparam int         n_phys_regs = 48;
    localparam int         fields      = 17;
    localparam int         max_lines   = 64;
    localparam int         margin_ns   = 200;
    localparam string      vec_path    = "dv/rename_testdata.hex";
    localparam logic [7:0] end_mark    = 8'hff;

    logic          clock;
    logic          rst_n;
    decode_pkt_t   decode;
    retire_pkt_t   retire;
    dispatch_pkt_t dispatch;
    logic          ready;
    logic [6:0]    free_count;

    // vector memory, fields tokens per line
    logic [7:0] vec_mem [fields*max_lines];
    int         n_lines;
    bit         loaded;

    int dispatch_errors;
    int ready_errors;
    int count_errors;
    int other_errors;

    rename_unit #(
        .n_phys_regs (n_phys_regs)
    ) u_rename_unit (
        .clock      (clock),
        .rst_n      (rst_n),
        .decode     (decode),
        .retire     (retire),
        .dispatch   (dispatch),
        .ready      (ready),
        .free_count (free_count)
    );

    initial begin
        clock = 1'b0;
        forever #(clk_period / 2) clock = ~clock;
    end

    //////////////////////////////////////////////////
    // vector access
    //////////////////////////////////////////////////

    function automatic logic [7:0] vec_field(input int line, input int col);
        return vec_mem[line*fields + col];
    endfunction

    // first column picks the behavior under test
    function automatic string line_name(input int line);
        string base;
        case (vec_field(line, 0))
            8'd1:    base = "reset_alloc";
            8'd2:    base = "raw_chain";
            8'd3:    base = "no_alloc";
            8'd4:    base = "drain_stall";
            8'd5:    base = "retire_fifo";
            default: base = "unknown";
        endcase
        return $sformatf("%s line %0d", base, line + 1);
    endfunction

    function automatic dispatch_pkt_t expected_dispatch(input int line);
        dispatch_pkt_t pkt;
        pkt.valid      = 1'(vec_field(line, 8));
        pkt.op         = op_class_t'(2'(vec_field(line, 9)));
        pkt.phys_src1  = phys_tag_t'(vec_field(line, 10));
        pkt.phys_src2  = phys_tag_t'(vec_field(line, 11));
        pkt.new_tag    = phys_tag_t'(vec_field(line, 12));
        pkt.old_tag    = phys_tag_t'(vec_field(line, 13));
        pkt.dest_alloc = 1'(vec_field(line, 14));
        return pkt;
    endfunction

    function automatic string format_dispatch(input dispatch_pkt_t pkt);
        return $sformatf("v%0d op%0d src1=%02h src2=%02h new=%02h old=%02h alloc%0d",
            pkt.valid, pkt.op, pkt.phys_src1, pkt.phys_src2, pkt.new_tag,
            pkt.old_tag, pkt.dest_alloc);
    endfunction

    //////////////////////////////////////////////////
    // compare tasks
    //////////////////////////////////////////////////

    task automatic check_dispatch(input string name, input dispatch_pkt_t expected,
                                  input dispatch_pkt_t actual);
        if (actual !== expected) begin
            dispatch_errors++;
            $display("FAILED %s dispatch: expected %s actual %s", name,
                format_dispatch(expected), format_dispatch(actual));
        end
    endtask

    task automatic check_ready(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            ready_errors++;
            $display("FAILED %s ready: expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic check_count(input string name, input logic [6:0] expected,
                               input logic [6:0] actual);
        if (actual !== expected) begin
            count_errors++;
            $display("FAILED %s free_count: expected %0d actual %0d", name, expected, actual);
        end
    endtask

    //////////////////////////////////////////////////
    // stimulus
    //////////////////////////////////////////////////

    task automatic load_vectors();
        int fd;
        bit found_end;
        fd = $fopen(vec_path, "r");
        if (fd == 0) begin
            other_errors++;
            $display("test data file %s is missing or cannot be read", vec_path);
            return;
        end
        $fclose(fd);
        $readmemh(vec_path, vec_mem);
        found_end = 1'b0;
        n_lines   = 0;
        // count lines up to the end marker
        for (int i = 0; i < max_lines; i++) begin
            if (!found_end) begin
                if (vec_field(i, 0) == end_mark) begin
                    found_end = 1'b1;
                end else begin
                    n_lines++;
                end
            end
        end
        if (!found_end || (n_lines == 0)) begin
            other_errors++;
            $display("test data file %s has no vectors or no end marker", vec_path);
            return;
        end
        loaded = 1'b1;
    endtask

    task automatic drive_line(input int line);
        decode.valid = 1'(vec_field(line, 1));
        decode.op    = op_class_t'(2'(vec_field(line, 2)));
        decode.src1  = arch_idx_t'(vec_field(line, 3));
        decode.src2  = arch_idx_t'(vec_field(line, 4));
        decode.dest  = arch_idx_t'(vec_field(line, 5));
        retire.valid = 1'(vec_field(line, 6));
        retire.tag   = phys_tag_t'(vec_field(line, 7));
    endtask

    // results of the rising edge after this line
    task automatic check_results(input int line);
        string name;
        name = line_name(line);
        check_dispatch(name, expected_dispatch(line), dispatch);
        check_count(name, 7'(vec_field(line, 16)), free_count);
    endtask

    task automatic run_vectors();
        string name;
        for (int i = 0; i < n_lines; i++) begin
            @(negedge clock);
            if (i > 0) begin
                check_results(i - 1);
            end
            drive_line(i);
            // ready settles well before the rising edge
            #2;
            name = line_name(i);
            check_ready(name, 1'(vec_field(i, 15)), ready);
        end
        @(negedge clock);
        check_results(n_lines - 1);
        decode = '0;
        retire = '0;
    endtask

    task automatic report_and_finish();
        int total;
        total = dispatch_errors + ready_errors + count_errors + other_errors;
        $display("errors: dispatch %0d, ready %0d, free_count %0d, other %0d, total %0d",
            dispatch_errors, ready_errors, count_errors, other_errors, total);
        if (total == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    endtask

    //////////////////////////////////////////////////
    // main sequence and watchdog
    //////////////////////////////////////////////////

    initial begin
        rst_n  = 1'b0;
        decode = '0;
        retire = '0;
        load_vectors();
        if (loaded) begin
            // two cycles of reset, released away from the edge
            repeat (2) @(posedge clock);
            @(negedge clock);
            rst_n = 1'b1;
            run_vectors();
        end
        report_and_finish();
    end

    // one clock per line plus reset and slack
    initial begin
        wait (loaded);
        #(n_lines * clk_period + margin_ns);
        other_errors++;
        $display("timeout: vectors did not complete within %0d ns",
            n_lines * clk_period + margin_ns);
        report_and_finish();
    end

endmodule

/* sim.f */
source/rename_pkg.sv
source/map_table.sv
source/free_list.sv
source/rename_stage.sv
source/rename_unit.sv
dv/rename_unit_tb.sv

/* source/free_list.sv */
//////////////////////////////////////////////////
// free list
// circular queue of free physical tags, pops at
// the head on allocate and pushes retired tags at
// the tail
//////////////////////////////////////////////////

`timescale 1ns/100ps

module free_list #(
    parameter int n_phys_regs = 48
) (
    input  logic                    clock,
    input  logic                    rst_n,

    // allocate side
    input  logic                    alloc,
    output rename_pkg::phys_tag_t   head_tag,
    output logic                    empty,

    // retire side, no handshake
    input  rename_pkg::retire_pkt_t retire,

    // number of free tags held
    output logic [6:0]              count
);
    import rename_pkg::*;

    // tags above the architectural range are the renaming pool
    localparam int depth = n_phys_regs - arch_regs;
    localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;

    //////////////////////////////////////////////////
    // storage and pointers
    //////////////////////////////////////////////////

    phys_tag_t        tags_q [depth];
    logic [ptr_w-1:0] head_q;
    logic [ptr_w-1:0] tail_q;
    logic             full;

    // wrap at depth, which need not be a power of two
    function automatic logic [ptr_w-1:0] ptr_inc(input logic [ptr_w-1:0] ptr);
        if (ptr == ptr_w'(depth - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign empty = (count == '0);
    assign full  = (count == 7'(depth));

    // head is read straight from the queue
    assign head_tag = tags_q[head_q];

    //////////////////////////////////////////////////
    // queue contents
    //////////////////////////////////////////////////

    // starts full with 32 upward, head at 32
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < depth; i++) begin
                tags_q[i] <= phys_tag_t'(arch_regs + i);
            end
        end else if (retire.valid) begin
            tags_q[tail_q] <= retire.tag;
        end
    end

    //////////////////////////////////////////////////
    // pointers and occupancy
    //////////////////////////////////////////////////

    // full list has tail sitting on head
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            head_q <= '0;
            tail_q <= '0;
            count  <= 7'(depth);
        end else begin
            if (alloc) begin
                head_q <= ptr_inc(head_q);
            end
            if (retire.valid) begin
                tail_q <= ptr_inc(tail_q);
            end
            // pop and push together leave count alone
            case ({alloc, retire.valid})
                2'b10:   count <= count - 7'd1;
                2'b01:   count <= count + 7'd1;
                default: count <= count;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    a_no_pop_empty : assert property (
        @(posedge clock) disable iff (!rst_n)
        alloc |-> !empty
    ) else $error("free list popped while empty");

    // every tag is already free, so a retire here is bogus
    a_no_push_full : assert property (
        @(posedge clock) disable iff (!rst_n)
        retire.valid |-> !full
    ) else $error("free list pushed while full");

endmodule

/* source/map_table.sv */
//////////////////////////////////////////////////
// map table
// architectural to physical tag mapping with two
// source read ports, a destination read port and
// one write port
//////////////////////////////////////////////////

`timescale 1ns/100ps

module map_table (
    input  logic                  clock,
    input  logic                  rst_n,

    // read indices from the rename stage
    input  rename_pkg::arch_idx_t src1_idx,
    input  rename_pkg::arch_idx_t src2_idx,
    input  rename_pkg::arch_idx_t dest_idx,

    // combinational read results
    output rename_pkg::phys_tag_t src1_tag,
    output rename_pkg::phys_tag_t src2_tag,
    output rename_pkg::phys_tag_t dest_old_tag,

    // new mapping for dest_idx
    input  logic                  wr_en,
    input  rename_pkg::phys_tag_t wr_tag
);
    import rename_pkg::*;

    //////////////////////////////////////////////////
    // mapping storage
    //////////////////////////////////////////////////

    // one tag per architectural register
    phys_tag_t map_q [arch_regs];

    // identity mapping out of reset
    // new tag lands at the edge, so reads this cycle
    // still see the previous mapping
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < arch_regs; i++) begin
                map_q[i] <= phys_tag_t'(i);
            end
        end else if (wr_en && (dest_idx != '0)) begin
            map_q[dest_idx] <= wr_tag;
        end
    end

    //////////////////////////////////////////////////
    // read ports
    //////////////////////////////////////////////////

    // r0 is hardwired to tag 0
    assign src1_tag = (src1_idx == '0) ? '0 : map_q[src1_idx];

    assign src2_tag = (src2_idx == '0) ? '0 : map_q[src2_idx];

    // old mapping of the destination, goes back to
    // the free list once the instruction retires
    assign dest_old_tag = (dest_idx == '0) ? '0 : map_q[dest_idx];

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // rename stage must never try to remap r0
    a_no_r0_write : assert property (
        @(posedge clock) disable iff (!rst_n)
        wr_en |-> (dest_idx != '0)
    ) else $error("map table write to architectural register 0");

endmodule

/* source/rename_pkg.sv */
//////////////////////////////////////////////////
// rename package
// register widths, physical tag type, op classes
// and the packets exchanged by the rename front end
//////////////////////////////////////////////////

package rename_pkg;

    //////////////////////////////////////////////////
    // register widths
    //////////////////////////////////////////////////

    // architectural register file
    localparam int arch_regs = 32;
    localparam int arch_w    = $clog2(arch_regs);

    typedef logic [arch_w-1:0] arch_idx_t;

    // physical tags, enough for up to 64 physical registers
    localparam int tag_w = 6;

    typedef logic [tag_w-1:0] phys_tag_t;

    //////////////////////////////////////////////////
    // operation class
    //////////////////////////////////////////////////

    // alu and load write a destination
    // store and branch never do
    typedef enum logic [1:0] {
        op_alu    = 2'b00,
        op_load   = 2'b01,
        op_store  = 2'b10,
        op_branch = 2'b11
    } op_class_t;

    //////////////////////////////////////////////////
    // packets
    //////////////////////////////////////////////////

    // decoded instruction from the decoder
    typedef struct packed {
        logic      valid;
        op_class_t op;
        arch_idx_t src1;
        arch_idx_t src2;
        arch_idx_t dest;
    } decode_pkt_t;

    // tag handed back at retirement
    typedef struct packed {
        logic      valid;
        phys_tag_t tag;
    } retire_pkt_t;

    // renamed instruction toward dispatch
    typedef struct packed {
        logic      valid;
        op_class_t op;
        phys_tag_t phys_src1;
        phys_tag_t phys_src2;
        phys_tag_t new_tag;
        phys_tag_t old_tag;
        // set when a fresh tag was taken
        logic      dest_alloc;
    } dispatch_pkt_t;

endpackage

/* source/rename_stage.sv */
//////////////////////////////////////////////////
// rename stage
// joins map table reads and the free-list head
// into the registered dispatch packet
//////////////////////////////////////////////////

`timescale 1ns/100ps

module rename_stage (
    input  logic                      clock,
    input  logic                      rst_n,

    // decoder side
    input  rename_pkg::decode_pkt_t   decode,
    output logic                      ready,

    // map table reads
    output rename_pkg::arch_idx_t     src1_idx,
    output rename_pkg::arch_idx_t     src2_idx,
    output rename_pkg::arch_idx_t     dest_idx,
    input  rename_pkg::phys_tag_t     src1_tag,
    input  rename_pkg::phys_tag_t     src2_tag,
    input  rename_pkg::phys_tag_t     dest_old_tag,

    // free list
    input  rename_pkg::phys_tag_t     head_tag,
    input  logic                      empty,
    output logic                      alloc,

    // map table write
    output logic                      wr_en,
    output rename_pkg::phys_tag_t     wr_tag,

    // renamed instruction, one cycle later
    output rename_pkg::dispatch_pkt_t dispatch
);
    import rename_pkg::*;

    logic          writes_dest;
    logic          need_tag;
    logic          accept;
    dispatch_pkt_t next_pkt;

    //////////////////////////////////////////////////
    // allocation decision
    //////////////////////////////////////////////////

    // only alu and load produce a result
    assign writes_dest = (decode.op == op_alu) || (decode.op == op_load);

    // r0 destination takes no tag
    assign need_tag = decode.valid && writes_dest && (decode.dest != '0);

    // stall only for a writer facing an empty list
    assign ready  = !(need_tag && empty);
    assign accept = decode.valid && ready;
    assign alloc  = accept && need_tag;

    // map reads, sources before own dest write
    assign src1_idx = decode.src1;
    assign src2_idx = decode.src2;
    assign dest_idx = decode.dest;

    // new mapping for the destination
    assign wr_en  = alloc;
    assign wr_tag = head_tag;

    //////////////////////////////////////////////////
    // dispatch packet
    //////////////////////////////////////////////////

    always_comb begin
        next_pkt = '0;
        if (accept) begin
            next_pkt.valid     = 1'b1;
            next_pkt.op        = decode.op;
            next_pkt.phys_src1 = src1_tag;
            next_pkt.phys_src2 = src2_tag;
            // dest tags stay zero unless a tag was taken
            if (alloc) begin
                next_pkt.new_tag    = head_tag;
                next_pkt.old_tag    = dest_old_tag;
                next_pkt.dest_alloc = 1'b1;
            end
        end
    end

    // one cycle, no back-pressure downstream
    always_ff @(posedge clock or negedge rst_n) begin
        if (!rst_n) begin
            dispatch <= '0;
        end else begin
            dispatch <= next_pkt;
        end
    end

endmodule

/* source/rename_unit.sv */
//////////////////////////////////////////////////
// rename unit
// register-renaming front end, map table and free
// list side by side feeding the rename stage
//////////////////////////////////////////////////

`timescale 1ns/100ps

module rename_unit #(
    parameter int n_phys_regs = 48
) (
    input  logic                      clock,
    input  logic                      rst_n,
    input  rename_pkg::decode_pkt_t   decode,
    input  rename_pkg::retire_pkt_t   retire,
    output rename_pkg::dispatch_pkt_t dispatch,
    output logic                      ready,
    output logic [6:0]                free_count
);
    import rename_pkg::*;

    //////////////////////////////////////////////////
    // internal wires
    //////////////////////////////////////////////////

    // map table read path
    arch_idx_t src1_idx;
    arch_idx_t src2_idx;
    arch_idx_t dest_idx;
    phys_tag_t src1_tag;
    phys_tag_t src2_tag;
    phys_tag_t dest_old_tag;

    // map table write
    logic      wr_en;
    phys_tag_t wr_tag;

    // free list
    phys_tag_t head_tag;
    logic      empty;
    logic      alloc;

    //////////////////////////////////////////////////
    // instances
    //////////////////////////////////////////////////

    map_table u_map_table (
        .clock        (clock),
        .rst_n        (rst_n),
        .src1_idx     (src1_idx),
        .src2_idx     (src2_idx),
        .dest_idx     (dest_idx),
        .src1_tag     (src1_tag),
        .src2_tag     (src2_tag),
        .dest_old_tag (dest_old_tag),
        .wr_en        (wr_en),
        .wr_tag       (wr_tag)
    );

    // pool depth comes from n_phys_regs
    free_list #(
        .n_phys_regs (n_phys_regs)
    ) u_free_list (
        .clock    (clock),
        .rst_n    (rst_n),
        .alloc    (alloc),
        .head_tag (head_tag),
        .empty    (empty),
        .retire   (retire),
        .count    (free_count)
    );

    rename_stage u_rename_stage (
        .clock        (clock),
        .rst_n        (rst_n),
        .decode       (decode),
        .ready        (ready),
        .src1_idx     (src1_idx),
        .src2_idx     (src2_idx),
        .dest_idx     (dest_idx),
        .src1_tag     (src1_tag),
        .src2_tag     (src2_tag),
        .dest_old_tag (dest_old_tag),
        .head_tag     (head_tag),
        .empty        (empty),
        .alloc        (alloc),
        .wr_en        (wr_en),
        .wr_tag       (wr_tag),
        .dispatch     (dispatch)
    );

endmodule
